// ==== tb.f ====
src/rom_sdram_pkg.sv
src/rom_map_pkg.sv
src/pxl_sync.sv
src/rom_arbiter.sv
src/sdram_seq.sv
src/romload_crc.sv
src/rom_sdram_top.sv
testbench/sdram_model.sv
testbench/tb_rom_sdram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rom_sdram -f tb.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }

// ==== testbench/tb_rom_sdram.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rom_sdram;
	import rom_map_pkg::*;

	localparam int INIT_WAIT = 64;
	localparam int N_LOAD = 256; // Words per region
	localparam int N_MAIN = 32;
	localparam int N_CHAR = 32;
	localparam int N_OBJ = 32;
	localparam int N_REF = 8;
	localparam int READ_LEN = 260;
	localparam int INIT_LEN = 16 + INIT_WAIT + 100;
	localparam int LOAD_LEN = 3 * N_LOAD * 20 + 40;
	localparam int READS_LEN = (N_MAIN + N_CHAR + N_OBJ) * READ_LEN;
	localparam int REF_LEN = 400 + N_REF * READ_LEN;
	localparam int LIMIT = 10 * (INIT_LEN + LOAD_LEN + READS_LEN + REF_LEN);

	logic clk, rst, clk_pxl;
	logic main_cs;
	logic [MAIN_AW-1:0] main_addr;
	logic [CHAR_AW-1:0] char_addr;
	logic [OBJ_AW-1:0] obj_addr;
	logic LVBL, downloading, romload_wr;
	logic [24:0] romload_addr;
	logic [15:0] romload_data;
	logic mrdy, ready;
	logic [7:0] main_dout;
	logic [15:0] char_dout;
	logic [31:0] obj_dout, crc_out;
	wire  [15:0] sdram_dq;
	logic [12:0] sdram_a;
	logic sdram_dqml, sdram_dqmh, sdram_cke;
	logic [1:0] sdram_ba;
	logic sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe;
	int refresh_cnt;
	logic early_access;

	logic [15:0] mirror [int unsigned];
	int unsigned main_words[$], char_words[$], obj_words[$];
	logic [31:0] crc_ref;
	int pxl_div;
	int cycles;
	int test_checks, test_errs, total_checks, total_errs;
	string test_name;

	rom_sdram_top #(.INIT_WAIT(INIT_WAIT)) dut (
		.clk(clk), .rst(rst), .clk_pxl(clk_pxl),
		.main_cs(main_cs), .main_addr(main_addr), .char_addr(char_addr), .obj_addr(obj_addr),
		.LVBL(LVBL), .downloading(downloading),
		.romload_addr(romload_addr), .romload_data(romload_data), .romload_wr(romload_wr),
		.mrdy(mrdy), .main_dout(main_dout), .char_dout(char_dout), .obj_dout(obj_dout),
		.ready(ready), .crc_out(crc_out),
		.sdram_dq(sdram_dq), .sdram_a(sdram_a), .sdram_dqml(sdram_dqml),
		.sdram_dqmh(sdram_dqmh), .sdram_ba(sdram_ba), .sdram_cke(sdram_cke),
		.sdram_ncs(sdram_ncs), .sdram_nras(sdram_nras), .sdram_ncas(sdram_ncas),
		.sdram_nwe(sdram_nwe)
	);

	sdram_model u_sdram_model (
		.clk(clk), .sdram_dq(sdram_dq), .sdram_a(sdram_a),
		.sdram_ncs(sdram_ncs), .sdram_nras(sdram_nras), .sdram_ncas(sdram_ncas),
		.sdram_nwe(sdram_nwe), .refresh_cnt(refresh_cnt), .early_access(early_access)
	);

	// Pixel clock toggles on falling clk edges, clear of the sampling edge
	initial begin
		clk = 1'b0;
		clk_pxl = 1'b0;
		pxl_div = 0;
		forever begin
			#5 clk = 1'b1;
			#5 clk = 1'b0;
			pxl_div++;
			if (pxl_div == 4) begin
				pxl_div = 0;
				clk_pxl = ~clk_pxl;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Error: run exceeded %0d cycles without finishing", LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [15:0] mirror_word(input int unsigned a);
		return mirror.exists(a) ? mirror[a] : 16'h0000;
	endfunction

	// CRC-32, poly 04C11DB7, MSB first, 16 bits per step
	function automatic logic [31:0] crc_advance(input logic [31:0] crc, input logic [15:0] d);
		logic [31:0] c;
		logic fb;
		c = crc;
		for (int i = 15; i >= 0; i--) begin
			fb = c[31] ^ d[i];
			c = c << 1;
			if (fb)
				c = c ^ 32'h04C11DB7;
		end
		return c;
	endfunction

	task automatic compare_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		test_checks++;
		assert (exp === act)
		else begin
			$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		test_checks++;
		assert (cond === 1'b1)
		else begin
			$display("Error: %s: %s", test_name, what);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		$display("Test %s done: %0d checks, %0d errors", test_name, test_checks, test_errs);
		total_checks += test_checks;
		total_errs += test_errs;
		test_checks = 0;
		test_errs = 0;
	endtask

	task automatic next_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ticks(input int n);
		repeat (n) @(negedge clk_pxl);
		repeat (4) @(posedge clk);
		#1;
	endtask

	task automatic load_word(input int unsigned w);
		logic [15:0] d;
		d = 16'($urandom);
		mirror[w] = d;
		crc_ref = crc_advance(crc_ref, d);
		romload_addr = 25'({w[21:0], 1'b0});
		romload_data = d; // Held until the next strobe
		romload_wr = 1'b1;
		next_edge();
		romload_wr = 1'b0;
		repeat (19) next_edge();
	endtask

	task automatic read_main(input int unsigned a);
		logic [15:0] w;
		int n;
		next_edge();
		main_addr = a[MAIN_AW-1:0];
		main_cs = 1'b1;
		repeat (2) @(negedge clk_pxl);
		repeat (2) next_edge();
		n = 0;
		while (!mrdy && n < 200) begin
			next_edge();
			n++;
		end
		check_true(mrdy, $sformatf("mrdy stayed low for main address %h", a));
		wait_ticks(2);
		w = mirror_word(a >> 1);
		compare_value("byte", {24'h0, a[0] ? w[15:8] : w[7:0]}, {24'h0, main_dout});
	endtask

	task automatic read_char(input int unsigned c);
		logic [15:0] exp;
		int n;
		next_edge();
		char_addr = c[CHAR_AW-1:0];
		if (c[12:3] == CHAR_SPACE)
			exp = 16'hFFFF;
		else
			exp = mirror_word(CHAR_BASE + c);
		n = 0;
		wait_ticks(1);
		while (char_dout !== exp && n < 16) begin
			wait_ticks(1);
			n++;
		end
		compare_value("word", {16'h0, exp}, {16'h0, char_dout});
	endtask

	task automatic read_obj(input int unsigned o);
		logic [31:0] exp;
		int n;
		next_edge();
		obj_addr = o[OBJ_AW-1:0];
		exp = {mirror_word(OBJ_BASE + 2 * o + 1), mirror_word(OBJ_BASE + 2 * o)};
		n = 0;
		wait_ticks(1);
		while (obj_dout !== exp && n < 16) begin
			wait_ticks(1);
			n++;
		end
		compare_value("words", exp, obj_dout);
	endtask

	function automatic int unsigned pick_main();
		int unsigned w;
		if ($urandom_range(0, 3) == 0)
			return $urandom_range(0, 17'h1FFFF); // Mostly unwritten space
		w = main_words[$urandom_range(0, main_words.size() - 1)];
		return 2 * w + $urandom_range(0, 1);
	endfunction

	initial begin
		int n;
		int unsigned w;
		int r0;
		rst = 1'b1;
		main_cs = 1'b0;
		main_addr = '0;
		char_addr = '0;
		obj_addr = '0;
		LVBL = 1'b0;
		downloading = 1'b0;
		romload_wr = 1'b0;
		romload_addr = '0;
		romload_data = '0;
		cycles = 0;
		test_checks = 0;
		test_errs = 0;
		total_checks = 0;
		total_errs = 0;
		test_name = "init";
		crc_ref = 32'hFFFFFFFF;
		void'($urandom(57543));

		repeat (16) @(posedge clk);
		#1 rst = 1'b0;
		n = 0;
		while (!ready && n < INIT_WAIT + 100) begin
			next_edge();
			n++;
		end
		check_true(ready, "ready did not rise after reset");
		check_true(!early_access, "SDRAM access seen before the load-mode command");
		// Packed as dqmh, dqml, ba, cke
		compare_value("fixed pins", 32'h1,
			{27'h0, sdram_dqmh, sdram_dqml, sdram_ba, sdram_cke});
		finish_test();

		test_name = "download";
		downloading = 1'b1;
		next_edge();
		for (int region = 0; region < 3; region++) begin
			for (int i = 0; i < N_LOAD; i++) begin
				do begin
					case (region)
						0: w = $urandom_range(0, 16'hFFFF);
						1: w = CHAR_BASE + $urandom_range(0, 13'h1FFF);
						default: w = OBJ_BASE + $urandom_range(0, 16'hFFFF);
					endcase
				end while (mirror.exists(w));
				load_word(w);
				if (region == 0)
					main_words.push_back(w);
				else if (region == 1)
					char_words.push_back(w - CHAR_BASE);
				else
					obj_words.push_back((w - OBJ_BASE) >> 1);
			end
		end
		repeat (20) next_edge();
		downloading = 1'b0;
		compare_value("crc", crc_ref, crc_out);
		finish_test();

		test_name = "main";
		LVBL = 1'b1;
		for (int i = 0; i < N_MAIN; i++)
			read_main(pick_main());
		finish_test();

		test_name = "char";
		for (int i = 0; i < N_CHAR; i++) begin
			if (i % 8 == 7)
				read_char({CHAR_SPACE, 3'($urandom_range(0, 7))});
			else
				read_char(char_words[$urandom_range(0, char_words.size() - 1)]);
		end
		finish_test();

		test_name = "obj";
		for (int i = 0; i < N_OBJ; i++)
			read_obj(obj_words[$urandom_range(0, obj_words.size() - 1)]);
		finish_test();

		// Vertical blank with every client hitting its cache
		test_name = "refresh";
		next_edge();
		LVBL = 1'b0;
		r0 = refresh_cnt;
		n = 0;
		while (refresh_cnt == r0 && n < 400) begin
			next_edge();
			n++;
		end
		check_true(refresh_cnt != r0, "no autorefresh seen during vertical blank");
		for (int i = 0; i < N_REF; i++)
			read_main(pick_main());
		finish_test();

		$display("Total: %0d checks, %0d errors", total_checks, total_errs);
		if (total_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/sdram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_model (
	input  logic clk,
	inout  wire  [15:0] sdram_dq,
	input  logic [12:0] sdram_a,
	input  logic sdram_ncs,
	input  logic sdram_nras,
	input  logic sdram_ncas,
	input  logic sdram_nwe,
	output int   refresh_cnt,
	output logic early_access
);
	import rom_sdram_pkg::*;

	logic [15:0] mem [int unsigned];
	logic [3:0] cmd;
	logic [12:0] row;
	logic [21:0] rd_addr;
	logic [1:0] rd_cnt;
	logic mode_seen;
	logic dq_oe;
	logic [15:0] dq_out;

	assign cmd = {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe};
	assign sdram_dq = dq_oe ? dq_out : 16'hzzzz;

	// Unwritten locations read back as zero
	function automatic logic [15:0] read_word(input logic [21:0] a);
		return mem.exists(int'(a)) ? mem[int'(a)] : 16'h0000;
	endfunction

	initial begin
		refresh_cnt  = 0;
		early_access = 1'b0;
		mode_seen    = 1'b0;
		rd_cnt       = 2'd0;
		dq_oe        = 1'b0;
		dq_out       = 16'h0000;
		row          = '0;
		rd_addr      = '0;
	end

	always @(posedge clk) begin
		case (cmd)
			CMD_ACTIVATE: row <= sdram_a;
			CMD_READ: begin
				if (!mode_seen)
					early_access <= 1'b1;
				rd_addr <= {row, sdram_a[8:0]};
				rd_cnt  <= 2'd1;
			end
			CMD_WRITE: begin
				if (!mode_seen)
					early_access <= 1'b1;
				mem[int'({row, sdram_a[8:0]})] = sdram_dq;
			end
			CMD_AUTOREFRESH: refresh_cnt <= refresh_cnt + 1;
			CMD_LOAD_MODE: mode_seen <= 1'b1;
			default: ;
		endcase
		// CAS latency 2, burst of two wrapping in the aligned pair
		if (rd_cnt == 2'd1) begin
			dq_out <= read_word(rd_addr);
			dq_oe  <= 1'b1;
			rd_cnt <= 2'd2;
		end else if (rd_cnt == 2'd2) begin
			dq_out <= read_word({rd_addr[21:1], ~rd_addr[0]});
			rd_cnt <= 2'd3;
		end else if (rd_cnt == 2'd3) begin
			dq_oe  <= 1'b0;
			rd_cnt <= 2'd0;
		end
	end

endmodule

`default_nettype wire

// ==== src/rom_sdram_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rom_sdram_top #(
	parameter int INIT_WAIT = 8400
) (
	input  logic clk,
	input  logic rst,
	input  logic clk_pxl,
	input  logic main_cs,
	input  logic [rom_map_pkg::MAIN_AW-1:0] main_addr,
	input  logic [rom_map_pkg::CHAR_AW-1:0] char_addr,
	input  logic [rom_map_pkg::OBJ_AW-1:0] obj_addr,
	input  logic LVBL,
	input  logic downloading,
	input  logic [24:0] romload_addr,
	input  logic [15:0] romload_data,
	input  logic romload_wr,
	output logic mrdy,
	output logic [7:0] main_dout,
	output logic [15:0] char_dout,
	output logic [31:0] obj_dout,
	output logic ready,
	output logic [31:0] crc_out,
	inout  wire  [15:0] sdram_dq,
	output logic [rom_sdram_pkg::ROW_W-1:0] sdram_a,
	output logic sdram_dqml,
	output logic sdram_dqmh,
	output logic [1:0] sdram_ba,
	output logic sdram_cke,
	output logic sdram_ncs,
	output logic sdram_nras,
	output logic sdram_ncas,
	output logic sdram_nwe
);
	import rom_map_pkg::*;

	logic pxl_tick;
	logic main_cs_s;
	logic [MAIN_AW-1:0] main_addr_s;
	logic [CHAR_AW-1:0] char_addr_s;
	logic [OBJ_AW-1:0] obj_addr_s;
	logic idle;
	logic rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic refresh_req;
	logic refresh_done;
	logic [15:0] rd_word;
	logic rd_word_valid;
	logic write_pulse;

	// Whole words, bank 0 only
	assign sdram_dqml = 1'b0;
	assign sdram_dqmh = 1'b0;
	assign sdram_ba   = 2'b00;
	assign sdram_cke  = 1'b1;

	pxl_sync u_pxl_sync (
		.clk         (clk),
		.rst         (rst),
		.clk_pxl     (clk_pxl),
		.main_cs     (main_cs),
		.main_addr   (main_addr),
		.char_addr   (char_addr),
		.obj_addr    (obj_addr),
		.pxl_tick    (pxl_tick),
		.main_cs_s   (main_cs_s),
		.main_addr_s (main_addr_s),
		.char_addr_s (char_addr_s),
		.obj_addr_s  (obj_addr_s)
	);

	rom_arbiter u_rom_arbiter (
		.clk           (clk),
		.rst           (rst),
		.pxl_tick      (pxl_tick),
		.main_cs_s     (main_cs_s),
		.main_addr_s   (main_addr_s),
		.char_addr_s   (char_addr_s),
		.obj_addr_s    (obj_addr_s),
		.LVBL          (LVBL),
		.downloading   (downloading),
		.idle          (idle),
		.rd_word       (rd_word),
		.rd_word_valid (rd_word_valid),
		.refresh_done  (refresh_done),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.refresh_req   (refresh_req),
		.mrdy          (mrdy),
		.main_dout     (main_dout),
		.char_dout     (char_dout),
		.obj_dout      (obj_dout)
	);

	sdram_seq #(
		.INIT_WAIT (INIT_WAIT)
	) u_sdram_seq (
		.clk           (clk),
		.rst           (rst),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.refresh_req   (refresh_req),
		.downloading   (downloading),
		.romload_wr    (romload_wr),
		.romload_addr  (romload_addr),
		.romload_data  (romload_data),
		.idle          (idle),
		.ready         (ready),
		.rd_word       (rd_word),
		.rd_word_valid (rd_word_valid),
		.refresh_done  (refresh_done),
		.write_pulse   (write_pulse),
		.sdram_dq      (sdram_dq),
		.sdram_a       (sdram_a),
		.sdram_ncs     (sdram_ncs),
		.sdram_nras    (sdram_nras),
		.sdram_ncas    (sdram_ncas),
		.sdram_nwe     (sdram_nwe)
	);

	romload_crc u_romload_crc (
		.clk          (clk),
		.rst          (rst),
		.write_pulse  (write_pulse),
		.romload_data (romload_data),
		.crc_out      (crc_out)
	);

endmodule

`default_nettype wire

// ==== src/romload_crc.sv ====
`timescale 1ns/100ps
`default_nettype none

module romload_crc (
	input  logic clk,
	input  logic rst,
	input  logic write_pulse,
	input  logic [15:0] romload_data,
	output logic [31:0] crc_out
);
	localparam logic [31:0] POLY = 32'h04C11DB7;

	// One 16-bit step, MSB first
	function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [15:0] data);
		logic [31:0] c;
		c = crc;
		for (int i = 15; i >= 0; i--) begin
			if (c[31] ^ data[i])
				c = {c[30:0], 1'b0} ^ POLY;
			else
				c = {c[30:0], 1'b0};
		end
		return c;
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			crc_out <= '1;
		else if (write_pulse)
			crc_out <= crc_step(crc_out, romload_data); // No final inversion
	end

endmodule

`default_nettype wire

// ==== src/sdram_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_seq #(
	parameter int INIT_WAIT = 8400
) (
	input  logic clk,
	input  logic rst,
	input  logic rd_req,
	input  logic [rom_map_pkg::ADDR_W-1:0] rd_addr,
	input  logic refresh_req,
	input  logic downloading,
	input  logic romload_wr,
	input  logic [24:0] romload_addr,
	input  logic [15:0] romload_data,
	output logic idle,
	output logic ready,
	output logic [15:0] rd_word,
	output logic rd_word_valid,
	output logic refresh_done,
	output logic write_pulse,
	inout  wire  [15:0] sdram_dq,
	output logic [rom_sdram_pkg::ROW_W-1:0] sdram_a,
	output logic sdram_ncs,
	output logic sdram_nras,
	output logic sdram_ncas,
	output logic sdram_nwe
);
	import rom_sdram_pkg::*;

	localparam int INIT_W = $clog2(INIT_WAIT + 1);

	typedef enum logic [3:0] {
		S_INIT,
		S_INIT_PRE,
		S_INIT_REF,
		S_INIT_MODE,
		S_IDLE,
		S_PRE,
		S_ACT,
		S_READ,
		S_DATA0,
		S_DATA1,
		S_WRITE,
		S_REF,
		S_WAIT
	} state_t;

	state_t state, next_state;
	sdram_cmd_t cmd;
	logic [3:0] wait_cnt;
	logic [INIT_W-1:0] init_cnt;
	logic init_ref_done;
	logic op_wr, op_ref;
	logic wr_pend;
	logic wr_accept;
	logic dq_oe;
	logic [ROW_W+COL_W-1:0] op_addr, wr_addr;
	logic [15:0] wr_data;

	assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
	assign sdram_dq = dq_oe ? wr_data : 16'hzzzz;
	assign idle = state == S_IDLE;
	assign wr_accept = romload_wr && downloading && ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= S_INIT;
			next_state    <= S_IDLE;
			cmd           <= CMD_INHIBIT;
			sdram_a       <= '0;
			wait_cnt      <= '0;
			init_cnt      <= INIT_W'(INIT_WAIT);
			init_ref_done <= 1'b0;
			op_wr         <= 1'b0;
			op_ref        <= 1'b0;
			wr_pend       <= 1'b0;
			dq_oe         <= 1'b0;
			ready         <= 1'b0;
			rd_word_valid <= 1'b0;
			refresh_done  <= 1'b0;
			write_pulse   <= 1'b0;
		end else begin
			cmd           <= CMD_NOP;
			dq_oe         <= 1'b0;
			rd_word_valid <= 1'b0;
			refresh_done  <= 1'b0;
			write_pulse   <= 1'b0;
			case (state)
				S_INIT:
					if (init_cnt == '0)
						state <= S_INIT_PRE;
					else
						init_cnt <= init_cnt - 1'b1;
				S_INIT_PRE, S_PRE: begin
					cmd      <= CMD_PRECHARGE;
					sdram_a  <= 13'h0400; // A10 selects all banks
					wait_cnt <= PRECHARGE_WAIT;
					state    <= S_WAIT;
					if (state == S_INIT_PRE)
						next_state <= S_INIT_REF;
					else
						next_state <= op_ref ? S_REF : S_ACT;
				end
				S_INIT_REF: begin
					cmd           <= CMD_AUTOREFRESH;
					wait_cnt      <= REFRESH_WAIT;
					state         <= S_WAIT;
					init_ref_done <= 1'b1;
					next_state    <= init_ref_done ? S_INIT_MODE : S_INIT_REF;
				end
				S_INIT_MODE: begin
					cmd        <= CMD_LOAD_MODE;
					sdram_a    <= MODE_WORD;
					ready      <= 1'b1;
					wait_cnt   <= 4'd2; // tMRD
					state      <= S_WAIT;
					next_state <= S_IDLE;
				end
				S_IDLE:
					if (wr_pend) begin
						op_wr  <= 1'b1;
						op_ref <= 1'b0;
						state  <= S_PRE;
					end else if (rd_req) begin
						op_wr  <= 1'b0;
						op_ref <= 1'b0;
						state  <= S_PRE;
					end else if (refresh_req) begin
						op_ref <= 1'b1;
						state  <= S_PRE;
					end
				S_ACT: begin
					cmd        <= CMD_ACTIVATE;
					sdram_a    <= op_addr[ROW_W+COL_W-1:COL_W];
					wait_cnt   <= ACTIVATE_WAIT;
					state      <= S_WAIT;
					next_state <= op_wr ? S_WRITE : S_READ;
				end
				S_READ: begin
					cmd        <= CMD_READ;
					sdram_a    <= ROW_W'(op_addr[COL_W-1:0]);
					wait_cnt   <= CAS_WAIT;
					state      <= S_WAIT;
					next_state <= S_DATA0;
				end
				S_DATA0: begin
					rd_word_valid <= 1'b1;
					state         <= S_DATA1;
				end
				S_DATA1: begin
					rd_word_valid <= 1'b1;
					state         <= S_IDLE;
				end
				S_WRITE: begin
					cmd         <= CMD_WRITE;
					sdram_a     <= ROW_W'(op_addr[COL_W-1:0]);
					dq_oe       <= 1'b1;
					write_pulse <= 1'b1;
					wr_pend     <= 1'b0;
					state       <= S_IDLE; // Idle cycle covers tWR
				end
				S_REF: begin
					cmd          <= CMD_AUTOREFRESH;
					refresh_done <= 1'b1; // Pulsed early so the request drops before idle
					wait_cnt     <= REFRESH_WAIT;
					state        <= S_WAIT;
					next_state   <= S_IDLE;
				end
				S_WAIT:
					if (wait_cnt == '0)
						state <= next_state;
					else
						wait_cnt <= wait_cnt - 1'b1;
				default: state <= S_IDLE;
			endcase
			if (wr_accept)
				wr_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			wr_addr <= romload_addr[ROW_W+COL_W:1]; // Byte to word address
			wr_data <= romload_data;
		end
		if (state == S_IDLE)
			op_addr <= wr_pend ? wr_addr : rd_addr;
		// Burst words land CL2 after the read command
		if (state == S_DATA0 || state == S_DATA1)
			rd_word <= sdram_dq;
	end

	// Arbiter must hold off reads for the whole download
	assert property (@(posedge clk) disable iff (rst) cmd == CMD_READ |-> !downloading)
		else $error("SDRAM read issued during download");

	// Only ROM-load writes drive the bus
	assert property (@(posedge clk) disable iff (rst) dq_oe |-> downloading)
		else $error("DQ driven outside ROM download");

endmodule

`default_nettype wire

// ==== src/rom_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rom_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic pxl_tick,
	input  logic main_cs_s,
	input  logic [rom_map_pkg::MAIN_AW-1:0] main_addr_s,
	input  logic [rom_map_pkg::CHAR_AW-1:0] char_addr_s,
	input  logic [rom_map_pkg::OBJ_AW-1:0] obj_addr_s,
	input  logic LVBL,
	input  logic downloading,
	input  logic idle,
	input  logic [15:0] rd_word,
	input  logic rd_word_valid,
	input  logic refresh_done,
	output logic rd_req,
	output logic [rom_map_pkg::ADDR_W-1:0] rd_addr,
	output logic refresh_req,
	output logic mrdy,
	output logic [7:0] main_dout,
	output logic [15:0] char_dout,
	output logic [31:0] obj_dout
);
	import rom_map_pkg::*;

	client_t cur, req_client;
	logic busy;
	logic word_hi; // Next word is the second of the burst
	logic [MAIN_AW-3:0] main_tag;
	logic [CHAR_AW-1:0] char_tag;
	logic [OBJ_AW-1:0] obj_tag;
	logic main_valid, char_valid, obj_valid;
	logic [31:0] main_cache, obj_cache;
	logic [15:0] char_cache;
	logic [31:0] main_line;
	logic main_fill_now, main_ok, main_miss;
	logic char_space, char_hit, obj_hit;
	logic char_req, obj_req, any_req;
	logic start;
	logic [ADDR_W-1:0] req_addr;

	// Second main word arriving this cycle counts as a hit already
	assign main_fill_now = rd_word_valid && word_hi && cur == CL_MAIN;
	assign main_ok = main_tag == main_addr_s[MAIN_AW-1:2] && (main_valid || main_fill_now);
	assign main_line = main_fill_now ? {rd_word, main_cache[15:0]} : main_cache;
	assign main_miss = main_cs_s && !main_ok;

	assign char_space = char_addr_s[CHAR_AW-1:3] == CHAR_SPACE;
	assign char_hit = char_valid && char_tag == char_addr_s;
	assign obj_hit = obj_valid && obj_tag == obj_addr_s;

	// Video layers only fetch during active lines
	assign char_req = LVBL && !char_space && !char_hit;
	assign obj_req = LVBL && !obj_hit;
	assign any_req = char_req || obj_req || main_miss;
	assign start = !busy && idle && !refresh_req && !downloading;

	always_comb begin
		if (char_req) begin
			req_client = CL_CHAR;
			req_addr   = CHAR_BASE + ADDR_W'(char_addr_s);
		end else if (obj_req) begin
			req_client = CL_OBJ;
			req_addr   = OBJ_BASE + ADDR_W'({obj_addr_s, 1'b0});
		end else begin
			req_client = CL_MAIN;
			req_addr   = MAIN_BASE + ADDR_W'({main_addr_s[MAIN_AW-1:2], 1'b0});
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cur         <= CL_NONE;
			busy        <= 1'b0;
			word_hi     <= 1'b0;
			rd_req      <= 1'b0;
			refresh_req <= 1'b0;
			mrdy        <= 1'b1;
			main_valid  <= 1'b0;
			char_valid  <= 1'b0;
			obj_valid   <= 1'b0;
			main_tag    <= '1;
			char_tag    <= '1;
			obj_tag     <= '1;
		end else begin
			rd_req <= 1'b0;
			if (start && any_req) begin
				busy    <= 1'b1;
				rd_req  <= 1'b1;
				word_hi <= 1'b0;
				cur     <= req_client;
				case (req_client)
					CL_CHAR: begin
						char_tag   <= char_addr_s;
						char_valid <= 1'b0;
					end
					CL_OBJ: begin
						obj_tag   <= obj_addr_s;
						obj_valid <= 1'b0;
					end
					default: begin
						main_tag   <= main_addr_s[MAIN_AW-1:2];
						main_valid <= 1'b0;
					end
				endcase
			end
			if (start && !any_req && !LVBL)
				refresh_req <= 1'b1;
			if (refresh_done)
				refresh_req <= 1'b0;
			if (pxl_tick && main_miss)
				mrdy <= 1'b0; // Stall main CPU
			if (rd_word_valid) begin
				word_hi <= !word_hi;
				if (!word_hi) begin
					if (cur == CL_MAIN)
						mrdy <= 1'b1;
					if (cur == CL_CHAR)
						char_valid <= 1'b1; // Char needs one word only
				end else begin
					busy <= 1'b0;
					cur  <= CL_NONE;
					if (cur == CL_MAIN)
						main_valid <= 1'b1;
					if (cur == CL_OBJ)
						obj_valid <= 1'b1;
				end
			end
			// ROM contents change under download
			if (downloading) begin
				main_valid <= 1'b0;
				char_valid <= 1'b0;
				obj_valid  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		rd_addr <= req_addr;
		if (rd_word_valid) begin
			case (cur)
				CL_MAIN:
					if (word_hi)
						main_cache[31:16] <= rd_word;
					else
						main_cache[15:0] <= rd_word;
				CL_CHAR:
					if (!word_hi)
						char_cache <= rd_word;
				CL_OBJ:
					if (word_hi)
						obj_cache[31:16] <= rd_word;
					else
						obj_cache[15:0] <= rd_word;
				default: ;
			endcase
		end
		if (pxl_tick) begin
			if (main_cs_s && main_ok)
				main_dout <= main_line[{main_addr_s[1:0], 3'b000} +: 8]; // Low byte first
			if (char_space)
				char_dout <= '1;
			else if (char_hit)
				char_dout <= char_cache;
			if (obj_hit)
				obj_dout <= obj_cache;
		end
	end

	// One read at a time, only into an idle sequencer
	assert property (@(posedge clk) disable iff (rst) rd_req |-> idle)
		else $error("rd_req issued while sequencer busy");

endmodule

`default_nettype wire

// ==== src/pxl_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module pxl_sync (
	input  logic clk,
	input  logic rst,
	input  logic clk_pxl,
	input  logic main_cs,
	input  logic [rom_map_pkg::MAIN_AW-1:0] main_addr,
	input  logic [rom_map_pkg::CHAR_AW-1:0] char_addr,
	input  logic [rom_map_pkg::OBJ_AW-1:0] obj_addr,
	output logic pxl_tick,
	output logic main_cs_s,
	output logic [rom_map_pkg::MAIN_AW-1:0] main_addr_s,
	output logic [rom_map_pkg::CHAR_AW-1:0] char_addr_s,
	output logic [rom_map_pkg::OBJ_AW-1:0] obj_addr_s
);
	logic [1:0] pxl_sr;
	logic pxl_fall;

	assign pxl_fall = pxl_sr[1] && !pxl_sr[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			pxl_sr      <= 2'b00;
			pxl_tick    <= 1'b0;
			main_cs_s   <= 1'b0;
			main_addr_s <= '0;
			char_addr_s <= '0;
			obj_addr_s  <= '0;
		end else begin
			pxl_sr   <= {pxl_sr[0], clk_pxl}; // Two-flop synchroniser
			pxl_tick <= pxl_fall;
			// Client buses are stable around the pixel clock falling edge
			if (pxl_fall) begin
				main_cs_s   <= main_cs;
				main_addr_s <= main_addr;
				char_addr_s <= char_addr;
				obj_addr_s  <= obj_addr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/rom_map_pkg.sv ====
`default_nettype none

package rom_map_pkg;

	typedef enum logic [1:0] {
		CL_NONE,
		CL_MAIN,
		CL_CHAR,
		CL_OBJ
	} client_t;

	// SDRAM word address
	localparam int ADDR_W = 22;

	// Region bases in words
	localparam logic [ADDR_W-1:0] MAIN_BASE = 22'h00000;
	localparam logic [ADDR_W-1:0] CHAR_BASE = 22'h0A000;
	localparam logic [ADDR_W-1:0] OBJ_BASE  = 22'h1C000;

	// Blank tile, compared against char address bits [12:3]
	localparam logic [9:0] CHAR_SPACE = 10'h020;

	localparam int MAIN_AW = 17; // Byte address
	localparam int CHAR_AW = 13;
	localparam int OBJ_AW  = 15;

endpackage

`default_nettype wire

// ==== src/rom_sdram_pkg.sv ====
`default_nettype none

package rom_sdram_pkg;

	// {ncs, nras, ncas, nwe}
	typedef enum logic [3:0] {
		CMD_LOAD_MODE   = 4'b0000,
		CMD_AUTOREFRESH = 4'b0001,
		CMD_PRECHARGE   = 4'b0010,
		CMD_ACTIVATE    = 4'b0011,
		CMD_WRITE       = 4'b0100,
		CMD_READ        = 4'b0101,
		CMD_NOP         = 4'b0111,
		CMD_INHIBIT     = 4'b1000
	} sdram_cmd_t;

	// Single-location writes, CAS latency 2, sequential burst of 2
	localparam logic [12:0] MODE_WORD = 13'b000_1_00_010_0_001;

	// Extra nop cycles after each command
	localparam logic [3:0] PRECHARGE_WAIT = 4'd1;
	localparam logic [3:0] ACTIVATE_WAIT  = 4'd0;
	localparam logic [3:0] CAS_WAIT       = 4'd1; // Matches CL2 capture point
	localparam logic [3:0] REFRESH_WAIT   = 4'd10;

	localparam int ROW_W = 13;
	localparam int COL_W = 9;

endpackage

`default_nettype wire
